// ==== dv/pe_comp_checker.sv ====
// checker of the PE control testbench
// builds the expected operation stream per layer, compares comp_en beats
`timescale 1ns/100ps
`default_nettype none
`include "pe_macros.svh"

module pe_comp_checker
  import pe_pkg::*;
#(
  parameter int NUM_BANKS = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         case_done,    // end of a case
  input  logic [15:0]                  exp_ops,      // ops per layer, from the table
  input  logic [NUM_BANKS-1:0][`PE_ACT_NO-1:0][`PE_DATA_WIDTH-1:0] rf_data,
  input  logic                         start_calc,
  input  logic [`LAYER_NO_WIDTH-1:0]   layer_no,
  input  logic [`ACT_NO_WIDTH-1:0]     in_act_no,
  input  logic [`ACT_NO_WIDTH-1:0]     out_act_no,
  input  logic [`W_MEM_ADDR_WIDTH-1:0] w_mem_offset,
  input  logic [`TRUNC_WIDTH-1:0]      act_trunc,
  input  logic                         in_act_relu,
  input  logic [`PE_ACT_NO-1:0]        in_act_nz,
  input  logic [`PE_ACT_NO-1:0]        in_act_gz,
  input  logic                         fin_comp,
  input  logic                         out_act_clear,
  input  logic                         act_regfile_dir,
  input  logic [`LAYER_NO_WIDTH-1:0]   layer_idx,
  input  comp_en_t                     comp_en,
  input  logic [`PE_ADDR_WIDTH-1:0]    in_act_idx,
  input  logic [`ACT_ADDR_WIDTH-1:0]   out_act_addr,
  input  logic [`PE_DATA_WIDTH-1:0]    in_act_value,
  input  logic [`W_MEM_ADDR_WIDTH-1:0] mem_offset,
  input  logic [`TRUNC_WIDTH-1:0]      trunc_amount,
  output int                           error_count,
  output int                           cases_run,
  output int                           cases_failed
);

  localparam int OP_W = `PE_ADDR_WIDTH + `ACT_ADDR_WIDTH + `PE_DATA_WIDTH
                      + `W_MEM_ADDR_WIDTH + `TRUNC_WIDTH;

  logic [OP_W-1:0] exp_q [$];  // expected ops of the running layer
  int              clr_cnt;    // layers started in this case
  int              fin_cnt;    // layers finished
  int              ops_seen;
  int              case_errs;
  logic            base_dir;   // regfile direction at start_calc

  function automatic logic [OP_W-1:0] pack_op(
    input logic [`PE_ADDR_WIDTH-1:0]    idx,
    input logic [`ACT_ADDR_WIDTH-1:0]   addr,
    input logic [`PE_DATA_WIDTH-1:0]    value,
    input logic [`W_MEM_ADDR_WIDTH-1:0] offset,
    input logic [`TRUNC_WIDTH-1:0]      trunc
  );
    return {idx, addr, value, offset, trunc};
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h expected 0x%0h (case %0d, layer %0d, op %0d)",
               name, got, exp, cases_run, fin_cnt, ops_seen);
      error_count++;
      case_errs++;
    end
  endtask

  task automatic report(input string what);
    $display("case %0d: %s", cases_run, what);
    error_count++;
    case_errs++;
  endtask

  // ------------------------------------------------------------------------
  // per-layer expectation: bias ops, then out_act_no ops per selected act
  // ------------------------------------------------------------------------
  task automatic start_layer();
    logic [`PE_ACT_NO-1:0] mask;
    int                    o;
    int                    a;
    check_field("layer_idx", layer_idx, clr_cnt);
    check_field("act_regfile_dir", act_regfile_dir, base_dir ^ clr_cnt[0]);
    mask = in_act_relu ? in_act_gz : in_act_nz;  // relu picks > 0
    for (o = 0; o < out_act_no; o++) begin
      exp_q.push_back(pack_op('0, `ACT_ADDR_WIDTH'(o), `PE_DATA_WIDTH'(1),
                              w_mem_offset, '0));
    end
    for (a = 0; a < in_act_no; a++) begin
      if (mask[a]) begin
        for (o = 0; o < out_act_no; o++) begin
          exp_q.push_back(pack_op(`PE_ADDR_WIDTH'(a + 1), `ACT_ADDR_WIDTH'(o),
                                  rf_data[clr_cnt][a], w_mem_offset, act_trunc));
        end
      end
    end
    clr_cnt++;
  endtask

  task automatic check_op();
    logic [`PE_ADDR_WIDTH-1:0]    e_idx;
    logic [`ACT_ADDR_WIDTH-1:0]   e_addr;
    logic [`PE_DATA_WIDTH-1:0]    e_val;
    logic [`W_MEM_ADDR_WIDTH-1:0] e_off;
    logic [`TRUNC_WIDTH-1:0]      e_trunc;
    if (exp_q.size() == 0) begin
      report("operation beat while no operation was expected");
    end else begin
      {e_idx, e_addr, e_val, e_off, e_trunc} = exp_q.pop_front();
      check_field("comp_en", comp_en, `COMP_EN_W);
      check_field("in_act_idx", in_act_idx, e_idx);
      check_field("out_act_addr", out_act_addr, e_addr);
      check_field("in_act_value", in_act_value, e_val);
      check_field("mem_offset", mem_offset, e_off);
      check_field("trunc_amount", trunc_amount, e_trunc);
    end
    ops_seen++;
  endtask

  task automatic check_fin();
    if (exp_q.size() != 0) begin
      report($sformatf("layer %0d ended with %0d operations missing",
                       fin_cnt, exp_q.size()));
    end
    check_field("layer_idx", layer_idx, fin_cnt);  // bumps after this cycle
    fin_cnt++;
  endtask

  task automatic close_case();
    if (clr_cnt != layer_no) begin
      report($sformatf("%0d output clears for %0d layers", clr_cnt, layer_no));
    end
    if (fin_cnt != layer_no) begin
      report($sformatf("%0d fin_comp pulses for %0d layers", fin_cnt, layer_no));
    end
    if (ops_seen != exp_ops * layer_no) begin
      report($sformatf("saw %0d operations, table gives %0d", ops_seen,
                       exp_ops * layer_no));
    end
    check_field("layer_idx", layer_idx, layer_no);
    if (case_errs == 0) begin
      $display("case %0d: ok, %0d layers, %0d operations", cases_run, fin_cnt, ops_seen);
    end else begin
      $display("case %0d: %0d errors", cases_run, case_errs);
      cases_failed++;
    end
    cases_run++;
  endtask

  // mid-cycle sampling, outputs settled
  always @(negedge clk) begin
    if (rst) begin
      error_count  = 0;
      cases_run    = 0;
      cases_failed = 0;
      clr_cnt      = 0;
      fin_cnt      = 0;
      ops_seen     = 0;
      case_errs    = 0;
      base_dir     = 1'b0;
      exp_q.delete();
    end else begin
      if (start_calc) begin
        base_dir  = act_regfile_dir;  // dir is not reset between runs
        clr_cnt   = 0;
        fin_cnt   = 0;
        ops_seen  = 0;
        case_errs = 0;
        exp_q.delete();
      end
      if (comp_en != COMP_IDLE) begin
        check_op();
      end
      if (fin_comp) begin
        check_fin();   // last op can share this cycle
      end
      if (out_act_clear) begin
        start_layer();
      end
      if (case_done) begin
        close_case();
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/pe_comp_tb.sv ====
// testbench of the PE computation control top
// clock, reset, register-file model, case table and run loop
`timescale 1ns/100ps
`default_nettype none
`include "pe_macros.svh"

module pe_comp_tb
  import pe_pkg::*;
();

  localparam int NUM_CASES   = 7;
  localparam int NUM_BANKS   = 8;     // one regfile bank per layer
  localparam int FIN_TIMEOUT = 1000;  // cycles allowed per layer

  logic                         clk;
  logic                         rst;
  logic                         start_calc;
  logic                         comp_done;
  logic [`LAYER_NO_WIDTH-1:0]   layer_no;
  logic [`ACT_NO_WIDTH-1:0]     in_act_no;
  logic [`ACT_NO_WIDTH-1:0]     out_act_no;
  logic [`W_MEM_ADDR_WIDTH-1:0] w_mem_offset;
  logic [`TRUNC_WIDTH-1:0]      act_trunc;
  logic                         in_act_relu;
  logic [`PE_ACT_NO-1:0]        in_act_nz;
  logic [`PE_ACT_NO-1:0]        in_act_gz;
  logic [`ACT_ADDR_WIDTH-1:0]   in_act_read_addr;
  logic [`PE_DATA_WIDTH-1:0]    in_act_read_data;
  logic                         fin_comp;
  logic                         out_act_clear;
  logic                         act_regfile_dir;
  logic [`LAYER_NO_WIDTH-1:0]   layer_idx;
  comp_en_t                     comp_en;
  logic [`PE_ADDR_WIDTH-1:0]    in_act_idx;
  logic [`ACT_ADDR_WIDTH-1:0]   out_act_addr;
  logic [`PE_DATA_WIDTH-1:0]    in_act_value;
  logic [`W_MEM_ADDR_WIDTH-1:0] mem_offset;
  logic [`TRUNC_WIDTH-1:0]      trunc_amount;

  logic [NUM_BANKS-1:0][`PE_ACT_NO-1:0][`PE_DATA_WIDTH-1:0] rf_data;
  logic [2:0]  rf_bank;      // layer the regfile serves
  logic        case_done;
  logic [15:0] exp_ops;
  int          error_count;
  int          cases_run;
  int          cases_failed;
  int          seed;
  bit          timed_out;

  // case table columns
  logic [`PE_ACT_NO-1:0] tbl_nz [NUM_CASES];
  logic [`PE_ACT_NO-1:0] tbl_gz [NUM_CASES];
  logic                  tbl_relu [NUM_CASES];
  int                    tbl_in_no [NUM_CASES];
  int                    tbl_out_no [NUM_CASES];
  int                    tbl_layers [NUM_CASES];
  int                    tbl_offset [NUM_CASES];
  int                    tbl_trunc [NUM_CASES];
  int                    tbl_ops [NUM_CASES];   // ops per layer

  always #10 clk = ~clk;

  assign in_act_read_data = rf_data[rf_bank][in_act_read_addr];  // same-cycle read

  pe_comp_top uut (.*);

  pe_comp_checker #(.NUM_BANKS(NUM_BANKS)) chk (.*);

  task automatic set_row(input int r, input logic [15:0] nz, input logic [15:0] gz,
                         input logic relu, input int in_no, input int out_no,
                         input int layers, input int offset, input int trunc,
                         input int ops);
    tbl_nz[r]     = nz;
    tbl_gz[r]     = gz;
    tbl_relu[r]   = relu;
    tbl_in_no[r]  = in_no;
    tbl_out_no[r] = out_no;
    tbl_layers[r] = layers;
    tbl_offset[r] = offset;
    tbl_trunc[r]  = trunc;
    tbl_ops[r]    = ops;
  endtask

  // ------------------------------------------------------------------------
  // case table
  // ------------------------------------------------------------------------
  task automatic load_table();
    //         nz        gz       relu in  out lay offset   tr ops
    set_row(0, 16'h00a5, 16'h0000, 0, 8,  4,  1, 10'h040, 3, 20);   // basic stream
    set_row(1, 16'hffff, 16'h0312, 1, 16, 3,  2, 10'h155, 5, 15);   // relu mask
    set_row(2, 16'hf3f3, 16'h0000, 0, 16, 16, 1, 10'h3ff, 15, 208); // queue fills
    set_row(3, 16'hff0f, 16'h0000, 0, 6,  2,  3, 10'h123, 1, 10);   // range limit
    set_row(4, 16'h1234, 16'h0000, 0, 16, 0,  2, 10'h2aa, 7, 0);    // no outputs
    set_row(5, 16'h0000, 16'h0000, 0, 16, 5,  2, 10'h001, 2, 5);    // bias only
    set_row(6, 16'hffff, 16'h0000, 0, 0,  2,  1, 10'h300, 4, 2);
  endtask

  task automatic fill_regfile();
    logic [`PE_DATA_WIDTH-1:0] v;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int s = 0; s < `PE_ACT_NO; s++) begin
        v = `PE_DATA_WIDTH'($random(seed));
        if (v == '0) begin
          v = 1;  // idx 0 value 0 is the end packet
        end
        rf_data[b][s] = v;
      end
    end
  endtask

  task automatic apply_row(input int r);
    @(posedge clk);
    #1;
    in_act_nz    = tbl_nz[r];
    in_act_gz    = tbl_gz[r];
    in_act_relu  = tbl_relu[r];
    in_act_no    = tbl_in_no[r];
    out_act_no   = tbl_out_no[r];
    layer_no     = tbl_layers[r];
    w_mem_offset = tbl_offset[r];
    act_trunc    = tbl_trunc[r];
    exp_ops      = tbl_ops[r];
    rf_bank      = '0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1;
    start_calc = 1'b1;
    @(posedge clk);
    #1;
    start_calc = 1'b0;
  endtask

  task automatic pulse_comp_done();
    @(posedge clk);
    #1;
    comp_done = 1'b1;
    rf_bank   = rf_bank + 1'b1;  // next layer reads the next bank
    @(posedge clk);
    #1;
    comp_done = 1'b0;
  endtask

  task automatic signal_case_done();
    @(posedge clk);
    #1;
    case_done = 1'b1;
    @(posedge clk);
    #1;
    case_done = 1'b0;
  endtask

  task automatic wait_for_fin(input int limit, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit) begin
      @(negedge clk);
      seen = fin_comp;
      cycles++;
    end
  endtask

  task automatic run_case(input int r);
    bit seen;
    apply_row(r);
    pulse_start();
    for (int l = 0; l < tbl_layers[r]; l++) begin
      wait_for_fin(FIN_TIMEOUT, seen);
      if (!seen) begin
        $display("timeout: case %0d layer %0d never raised fin_comp", r, l);
        timed_out = 1'b1;
        return;
      end
      repeat (3) @(posedge clk);  // datapath still busy
      pulse_comp_done();
    end
    repeat (4) @(posedge clk);
    signal_case_done();
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    start_calc   = 1'b0;
    comp_done    = 1'b0;
    layer_no     = 1;
    in_act_no    = '0;
    out_act_no   = '0;
    w_mem_offset = '0;
    act_trunc    = '0;
    in_act_relu  = 1'b0;
    in_act_nz    = '0;
    in_act_gz    = '0;
    rf_bank      = '0;
    case_done    = 1'b0;
    exp_ops      = '0;
    timed_out    = 1'b0;
    seed         = 55;
    load_table();
    fill_regfile();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < NUM_CASES && !timed_out; r++) begin
      run_case(r);
    end
    repeat (2) @(posedge clk);
    $display("summary: %0d cases run, %0d failed, %0d errors",
             cases_run, cases_failed, error_count);
    if (!timed_out && error_count == 0 && cases_failed == 0 && cases_run == NUM_CASES) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/act_broadcast.sv ====
// activation broadcaster
// scans the nonzero mask, pushes index/value entries and the end packet
`timescale 1ns/100ps
`default_nettype none
`include "pe_macros.svh"

module act_broadcast
  import pe_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start_broadcast,   // one-cycle pulse
  input  logic                       in_act_relu,
  input  logic [`PE_ACT_NO-1:0]      in_act_nz,
  input  logic [`PE_ACT_NO-1:0]      in_act_gz,
  input  logic [`ACT_NO_WIDTH-1:0]   in_act_no,         // scan limit
  output logic [`ACT_ADDR_WIDTH-1:0] in_act_read_addr,
  input  logic [`PE_DATA_WIDTH-1:0]  in_act_read_data,  // same-cycle return
  input  logic                       full,
  output logic                       push,
  output act_entry_t                 push_entry
);

  logic                       busy;          // scan in progress
  logic [`ACT_NO_WIDTH-1:0]   scan_start;    // search start of current cand
  logic [`ACT_NO_WIDTH-1:0]   search_start;
  logic [`PE_ACT_NO-1:0]      scan_mask;
  logic [`ACT_ADDR_WIDTH-1:0] lnzd_pos;
  logic                       lnzd_valid;
  logic [`ACT_ADDR_WIDTH-1:0] cand_pos;      // registered search result
  logic                       cand_valid;

  assign scan_mask = in_act_relu ? in_act_gz : in_act_nz;  // relu takes > 0

  // where the next search begins
  always_comb begin
    if (start_broadcast) begin
      search_start = '0;
    end else if (push && cand_valid) begin
      // step past the slot just pushed
      search_start = {{(`ACT_NO_WIDTH-`ACT_ADDR_WIDTH){1'b0}}, cand_pos} + 1'b1;
    end else begin
      search_start = scan_start;  // hold under back-pressure
    end
  end

  // ------------------------------------------------------------------------
  // leading nonzero within [search_start, in_act_no)
  // ------------------------------------------------------------------------
  always_comb begin
    lnzd_pos   = '0;
    lnzd_valid = 1'b0;
    for (int i = `PE_ACT_NO-1; i >= 0; i--) begin   // downward so lowest wins
      if (scan_mask[i] && (i >= search_start) && (i < in_act_no)) begin
        lnzd_pos   = i[`ACT_ADDR_WIDTH-1:0];
        lnzd_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy       <= 1'b0;
      scan_start <= '0;
      cand_pos   <= '0;
      cand_valid <= 1'b0;
    end else begin
      scan_start <= search_start;
      cand_pos   <= lnzd_pos;    // cuts the search off the push path
      cand_valid <= lnzd_valid;
      if (start_broadcast) begin
        busy <= 1'b1;
      end else if (push && !cand_valid) begin
        busy <= 1'b0;            // end packet went out
      end
    end
  end

  assign push             = busy & ~full;
  assign in_act_read_addr = cand_pos;

  // candidate entry, or the end packet once nothing is left
  always_comb begin
    push_entry = '0;
    if (cand_valid) begin
      push_entry.idx   = cand_pos;
      push_entry.value = in_act_read_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/act_queue.sv ====
// activation queue between broadcaster and controller
// circular buffer with empty, empty-next and full flags
`timescale 1ns/100ps
`default_nettype none
`include "pe_macros.svh"

module act_queue
  import pe_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  act_entry_t push_entry,
  input  logic       pop,
  output act_entry_t head_entry,
  output logic       empty,
  output logic       empty_next,  // empty after this pop, no push
  output logic       full
);

  logic [`ACT_ENTRY_WIDTH-1:0]     mem [`ACT_QUEUE_DEPTH];
  logic [`ACT_QUEUE_PTR_WIDTH-1:0] wr_ptr;
  logic [`ACT_QUEUE_PTR_WIDTH-1:0] rd_ptr;
  logic [`ACT_QUEUE_PTR_WIDTH:0]   count;   // extra bit to reach depth

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  assign head_entry = act_entry_t'(mem[rd_ptr]);  // visible a cycle after push
  assign empty      = (count == '0);
  assign full       = (count == `ACT_QUEUE_DEPTH);
  assign empty_next = (count == 1) & ~push;

  // broadcaster honours the full level
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> !full);
  // controller only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop |-> !empty);

endmodule

`default_nettype wire

// ==== hw/pe_comp_ctrl.sv ====
// computation controller of the PE
// bias, weight and layer-sync stages, registered datapath outputs
`timescale 1ns/100ps
`default_nettype none
`include "pe_macros.svh"

module pe_comp_ctrl
  import pe_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start_calc,
  input  logic                         comp_done,
  input  logic [`LAYER_NO_WIDTH-1:0]   layer_no,      // total layers
  input  logic [`ACT_NO_WIDTH-1:0]     out_act_no,
  input  logic [`W_MEM_ADDR_WIDTH-1:0] w_mem_offset,
  input  logic [`TRUNC_WIDTH-1:0]      act_trunc,
  input  logic                         empty,
  input  logic                         empty_next,
  input  act_entry_t                   head_entry,
  output logic                         pop,
  output logic                         start_broadcast,
  output logic                         fin_comp,
  output logic                         out_act_clear,
  output logic                         act_regfile_dir,
  output logic [`LAYER_NO_WIDTH-1:0]   layer_idx,
  output comp_en_t                     comp_en,
  output logic [`PE_ADDR_WIDTH-1:0]    in_act_idx,
  output logic [`ACT_ADDR_WIDTH-1:0]   out_act_addr,
  output logic [`PE_DATA_WIDTH-1:0]    in_act_value,
  output logic [`W_MEM_ADDR_WIDTH-1:0] mem_offset,
  output logic [`TRUNC_WIDTH-1:0]      trunc_amount
);

  ctrl_state_t                   state;
  ctrl_state_t                   state_next;
  logic [`LAYER_NO_WIDTH-1:0]    layer_idx_next;
  logic                          dir_next;
  logic                          clear_next;
  logic                          start_next;
  logic [`ACT_NO_WIDTH-1:0]      out_act_cnt;     // output act being issued
  logic [`ACT_NO_WIDTH-1:0]      cnt_next;
  logic [`ACT_NO_WIDTH-1:0]      cnt_inc;
  logic                          cnt_last;
  // datapath d inputs
  comp_en_t                      comp_en_d;
  logic [`PE_ADDR_WIDTH-1:0]     in_act_idx_d;
  logic [`ACT_ADDR_WIDTH-1:0]    out_act_addr_d;
  logic [`PE_DATA_WIDTH-1:0]     in_act_value_d;
  logic [`W_MEM_ADDR_WIDTH-1:0]  mem_offset_d;
  logic [`TRUNC_WIDTH-1:0]       trunc_d;

  assign cnt_last = (out_act_cnt == out_act_no - 1'b1);   // never hit for 0
  assign cnt_inc  = cnt_last ? '0 : out_act_cnt + 1'b1;

  // ------------------------------------------------------------------------
  // next-state and operation decode
  // ------------------------------------------------------------------------
  always_comb begin
    state_next     = state;
    layer_idx_next = layer_idx;
    dir_next       = act_regfile_dir;
    cnt_next       = out_act_cnt;
    clear_next     = 1'b0;
    start_next     = 1'b0;
    pop            = 1'b0;
    fin_comp       = 1'b0;
    comp_en_d      = COMP_IDLE;
    in_act_idx_d   = '0;       // bias index and zero trunc by default
    out_act_addr_d = '0;
    in_act_value_d = '0;
    mem_offset_d   = '0;
    trunc_d        = '0;

    case (state)
      ST_IDLE: begin
        if (start_calc) begin
          state_next     = (out_act_no == '0) ? ST_WEIGHT : ST_BIAS;
          layer_idx_next = '0;
          cnt_next       = '0;
          clear_next     = 1'b1;
          start_next     = 1'b1;
        end
      end
      ST_BIAS: begin
        // bias op, value one
        comp_en_d      = COMP_W;
        in_act_value_d = {{(`PE_DATA_WIDTH-1){1'b0}}, 1'b1};
        out_act_addr_d = out_act_cnt[`ACT_ADDR_WIDTH-1:0];
        mem_offset_d   = w_mem_offset;
        cnt_next       = cnt_inc;
        if (cnt_last) begin
          state_next = ST_WEIGHT;
        end
      end
      ST_WEIGHT: begin
        if (!empty) begin
          if (head_entry != '0) begin
            if (out_act_no != '0) begin
              comp_en_d      = COMP_W;
              in_act_idx_d   = {{(`PE_ADDR_WIDTH-`ACT_ADDR_WIDTH){1'b0}},
                                head_entry.idx} + 1'b1;   // skip bias slot
              in_act_value_d = head_entry.value;
              out_act_addr_d = out_act_cnt[`ACT_ADDR_WIDTH-1:0];
              mem_offset_d   = w_mem_offset;
              trunc_d        = act_trunc;
              cnt_next       = cnt_inc;
            end
            pop = cnt_last || (out_act_no == '0);  // entry done
          end else begin
            // end packet
            pop            = 1'b1;
            fin_comp       = 1'b1;
            layer_idx_next = layer_idx + 1'b1;
            state_next     = ST_LAYER_SYNC;
          end
        end
      end
      ST_LAYER_SYNC: begin
        if (comp_done) begin
          if (layer_idx == layer_no) begin
            state_next = ST_IDLE;          // all layers done
          end else begin
            state_next = (out_act_no == '0) ? ST_WEIGHT : ST_BIAS;
            cnt_next   = '0;
            clear_next = 1'b1;
            start_next = 1'b1;
            dir_next   = ~act_regfile_dir; // outputs become next inputs
          end
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state           <= ST_IDLE;
      layer_idx       <= '0;
      act_regfile_dir <= 1'b0;
      out_act_cnt     <= '0;
      out_act_clear   <= 1'b0;
      start_broadcast <= 1'b0;
      comp_en         <= COMP_IDLE;
    end else begin
      state           <= state_next;
      layer_idx       <= layer_idx_next;
      act_regfile_dir <= dir_next;
      out_act_cnt     <= cnt_next;
      out_act_clear   <= clear_next;
      start_broadcast <= start_next;
      comp_en         <= comp_en_d;
    end
  end

  // operands, qualified downstream by comp_en
  always_ff @(posedge clk) begin
    in_act_idx   <= in_act_idx_d;
    out_act_addr <= out_act_addr_d;
    in_act_value <= in_act_value_d;
    mem_offset   <= mem_offset_d;
    trunc_amount <= trunc_d;
  end

  // end packet must be the last entry the broadcaster queued
  a_fin_last: assert property (@(posedge clk) disable iff (rst)
    fin_comp |-> empty_next);
  a_comp_en_legal: assert property (@(posedge clk) disable iff (rst)
    comp_en inside {COMP_IDLE, COMP_W});

endmodule

`default_nettype wire

// ==== hw/pe_comp_top.sv ====
// PE computation control top
// broadcaster, activation queue and controller
`timescale 1ns/100ps
`default_nettype none
`include "pe_macros.svh"

module pe_comp_top
  import pe_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start_calc,
  input  logic                         comp_done,
  input  logic [`LAYER_NO_WIDTH-1:0]   layer_no,
  input  logic [`ACT_NO_WIDTH-1:0]     in_act_no,
  input  logic [`ACT_NO_WIDTH-1:0]     out_act_no,
  input  logic [`W_MEM_ADDR_WIDTH-1:0] w_mem_offset,
  input  logic [`TRUNC_WIDTH-1:0]      act_trunc,
  input  logic                         in_act_relu,
  input  logic [`PE_ACT_NO-1:0]        in_act_nz,
  input  logic [`PE_ACT_NO-1:0]        in_act_gz,
  output logic [`ACT_ADDR_WIDTH-1:0]   in_act_read_addr,
  input  logic [`PE_DATA_WIDTH-1:0]    in_act_read_data,
  output logic                         fin_comp,
  output logic                         out_act_clear,
  output logic                         act_regfile_dir,
  output logic [`LAYER_NO_WIDTH-1:0]   layer_idx,
  output comp_en_t                     comp_en,
  output logic [`PE_ADDR_WIDTH-1:0]    in_act_idx,
  output logic [`ACT_ADDR_WIDTH-1:0]   out_act_addr,
  output logic [`PE_DATA_WIDTH-1:0]    in_act_value,
  output logic [`W_MEM_ADDR_WIDTH-1:0] mem_offset,
  output logic [`TRUNC_WIDTH-1:0]      trunc_amount
);

  // ------------------------------------------------------------------------
  // internal links
  // ------------------------------------------------------------------------
  logic       start_broadcast;  // controller to broadcaster
  logic       push;
  logic       full;
  act_entry_t push_entry;
  logic       pop;
  logic       empty;
  logic       empty_next;
  act_entry_t head_entry;

  act_broadcast u_bcast (
    .clk, .rst, .start_broadcast, .in_act_relu, .in_act_nz, .in_act_gz,
    .in_act_no, .in_act_read_addr, .in_act_read_data,
    .full, .push, .push_entry
  );

  act_queue u_queue (
    .clk, .rst, .push, .push_entry, .pop,
    .head_entry, .empty, .empty_next, .full
  );

  pe_comp_ctrl u_ctrl (
    .clk, .rst, .start_calc, .comp_done, .layer_no, .out_act_no,
    .w_mem_offset, .act_trunc, .empty, .empty_next, .head_entry, .pop,
    .start_broadcast, .fin_comp, .out_act_clear, .act_regfile_dir,
    .layer_idx, .comp_en, .in_act_idx, .out_act_addr, .in_act_value,
    .mem_offset, .trunc_amount
  );

endmodule

`default_nettype wire

// ==== hw/pe_macros.svh ====
// widths and depths of the sparse PE control path
// activation queue sizing and compute-enable codes
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// activation register file side
// slots per PE
`define PE_ACT_NO           16
`define ACT_ADDR_WIDTH      4
// wide enough for a count of 16
`define ACT_NO_WIDTH        5
`define PE_DATA_WIDTH       16

// datapath side, index 0 is the bias
`define PE_ADDR_WIDTH       5
`define W_MEM_ADDR_WIDTH    10
`define TRUNC_WIDTH         4
`define LAYER_NO_WIDTH      4

// activation queue
`define ACT_QUEUE_DEPTH     4
`define ACT_QUEUE_PTR_WIDTH 2
`define ACT_ENTRY_WIDTH     (`ACT_ADDR_WIDTH + `PE_DATA_WIDTH)

// compute enable codes
`define COMP_EN_IDLE        2'd0
`define COMP_EN_W           2'd1

`endif

// ==== hw/pe_pkg.sv ====
// shared types of the PE control path
// controller states, compute enable, queue entry
`default_nettype none
`include "pe_macros.svh"

package pe_pkg;

  // controller FSM states
  typedef enum logic [1:0] {
    ST_IDLE,        // waiting for start_calc
    ST_BIAS,        // one bias op per output act
    ST_WEIGHT,      // weight ops from the queue
    ST_LAYER_SYNC   // wait for comp_done
  } ctrl_state_t;

  // compute enable toward the MAC array
  typedef enum logic [1:0] {
    COMP_IDLE = `COMP_EN_IDLE,
    COMP_W    = `COMP_EN_W
  } comp_en_t;

  // queue payload
  // an all-zero entry is the end packet
  typedef struct packed {
    logic [`ACT_ADDR_WIDTH-1:0] idx;    // input act slot
    logic [`PE_DATA_WIDTH-1:0]  value;  // read from the regfile
  } act_entry_t;

endpackage

`default_nettype wire

// ==== pe_comp_top.f ====
+incdir+hw
hw/pe_pkg.sv
hw/act_broadcast.sv
hw/act_queue.sv
hw/pe_comp_ctrl.sv
hw/pe_comp_top.sv
dv/pe_comp_checker.sv
dv/pe_comp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the PE control testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pe_comp_tb \
  -f pe_comp_top.f -Mdir obj_dir -o pe_comp_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/pe_comp_sim > sim.log 2>&1
cat sim.log
grep -qx '\*\*\* PASSED \*\*\*' sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }
